/* filelist.f */
+incdir+.
crt_pkg.sv
crt_bank_table.sv
crt_mapper_ctrl.sv
crt_addr_xlate.sv
cartridge.sv
tb_cartridge.sv

/* Makefile */
# Verilator build and run for the cartridge mapper testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cartridge
FILELIST  = filelist.f

SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) crt_params.svh
BIN     = obj_dir/V$(TOP)

.PHONY: all run test clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee sim.log

test: run
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_cartridge.sv */
// Testbench for the cartridge mapper with stimulus table, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

`include "crt_params.svh"

module tb_cartridge;
	import crt_pkg::*;

	typedef enum logic [2:0] {
		OP_ID, OP_LOAD, OP_IOW, OP_IOR, OP_RDL, OP_RDH, OP_WRL, OP_RAMW
	} op_e;

	// One table row with load fields or CPU fields by op
	typedef struct packed {
		op_e         op;
		logic [15:0] arg;       // Cart id or first bank number
		logic [7:0]  reps;      // Banks loaded by this row
		logic [15:0] laddr;
		logic [15:0] size;
		crt_addr_t   raddr;
		logic [17:0] addr;
		logic [7:0]  data;
		logic [7:0]  mask;      // Data bits that matter
		logic [1:0]  lines;     // Expected {exrom, game}
		crt_addr_t   exp_addr;
		logic        flt;
		logic        wren;
	} row_t;

	logic       clk32;
	logic       reset_n;
	logic       cart_loading;
	crt_id_t    cart_id;
	crt_load_t  load;
	crt_bus_t   bus;
	logic       cart_exrom0;
	logic       cart_game0;
	logic       exrom;
	logic       game;
	crt_addr_t  addr_out;
	logic       mem_write_out;
	logic       data_floating;

	row_t        rows [$];
	int          row_idx = 0;
	int          cycles = 0;
	logic [31:0] rng_state = 32'hbb56ee5c;

	cartridge i_cartridge (
		.clk32         (clk32),
		.reset_n       (reset_n),
		.cart_loading  (cart_loading),
		.cart_id       (cart_id),
		.load          (load),
		.bus           (bus),
		.cart_exrom0   (cart_exrom0),
		.cart_game0    (cart_game0),
		.exrom         (exrom),
		.game          (game),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out),
		.data_floating (data_floating)
	);

	always #2 clk32 = ~clk32;

	// ******************************
	// Row builders
	// ******************************

	function automatic row_t set_id(input crt_id_t id);
		row_t r;
		r = '0;
		r.op = OP_ID;
		r.arg = id;
		return r;
	endfunction

	function automatic row_t load_banks(input logic [15:0] num, input logic [7:0] reps,
		input logic [15:0] laddr, input logic [15:0] size, input crt_addr_t raddr);
		row_t r;
		r = '0;
		r.op = OP_LOAD;
		r.arg = num;
		r.reps = reps;
		r.laddr = laddr;
		r.size = size;
		r.raddr = raddr;    // Steps by 8K per extra bank
		return r;
	endfunction

	function automatic row_t cpu_step(input op_e op, input logic [17:0] addr,
		input logic [7:0] data, input logic [7:0] mask, input logic [1:0] lines,
		input crt_addr_t exp_addr, input logic flt, input logic wren);
		row_t r;
		r = '{op, 16'd0, 8'd0, 16'd0, 16'd0, 25'd0, addr, data, mask, lines, exp_addr, flt, wren};
		return r;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ******************************
	// Stimulus table
	// ******************************

	task automatic fill_table();
		// Generic 16K image where ROMH follows lo[0] + 1
		rows.push_back(set_id(`CRT_ID_GENERIC));
		rows.push_back(load_banks(16'd0, 8'd1, 16'h8000, 16'h4000, 25'h0104000));
		rows.push_back(cpu_step(OP_RDL, 18'h00123, 8'h00, 8'h00, 2'b00, 25'h0104123, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_RDH, 18'h0A456, 8'h00, 8'h00, 2'b00, 25'h0106456, 1'b0, 1'b0));
		// Ocean bank 32 lifts GAME
		rows.push_back(set_id(`CRT_ID_OCEAN));
		rows.push_back(load_banks(16'd0, 8'd2, 16'h8000, 16'h2000, 25'h0100000));
		rows.push_back(cpu_step(OP_IOW, 18'h0DE00, 8'h55, 8'h7F, 2'b00, 25'h0, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_RDL, 18'h00010, 8'h00, 8'h00, 2'b00, 25'h012A010, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_RDH, 18'h0A020, 8'h00, 8'h00, 2'b00, 25'h012A020, 1'b0, 1'b0));
		rows.push_back(load_banks(16'd32, 8'd1, 16'h8000, 16'h2000, 25'h0140000));
		rows.push_back(cpu_step(OP_IOR, 18'h0DE00, 8'h00, 8'h00, 2'b01, 25'h0, 1'b0, 1'b0));
		// Magic Desk with 20 banks keeps data bits 4:0
		rows.push_back(set_id(`CRT_ID_MAGICDESK));
		rows.push_back(load_banks(16'd0, 8'd20, 16'h8000, 16'h2000, 25'h0100000));
		rows.push_back(cpu_step(OP_IOW, 18'h0DE00, 8'hB3, 8'hBF, 2'b11, 25'h0, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_RDL, 18'h00200, 8'h00, 8'h00, 2'b11, 25'h0126200, 1'b0, 1'b0));
		// EasyFlash with lo at 4 and 5 and hi at 6 and 7
		rows.push_back(load_banks(16'd0, 8'd2, 16'h8000, 16'h2000, 25'h0108000));
		rows.push_back(load_banks(16'd0, 8'd2, 16'hA000, 16'h2000, 25'h010C000));
		rows.push_back(set_id(`CRT_ID_EASYFLASH));
		rows.push_back(cpu_step(OP_RDL, 18'h00300, 8'h00, 8'h00, 2'b10, 25'h0108300, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_WRL, 18'h00301, 8'h00, 8'h00, 2'b10, 25'h0000301, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_RAMW, 18'h01234, 8'h00, 8'h00, 2'b10, 25'h0001234, 1'b0, 1'b1));
		rows.push_back(cpu_step(OP_IOW, 18'h0DE00, 8'h01, 8'h3F, 2'b10, 25'h0, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_RDL, 18'h00004, 8'h00, 8'h00, 2'b10, 25'h010A004, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_RDH, 18'h0A008, 8'h00, 8'h00, 2'b10, 25'h010E008, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_IOW, 18'h0DE02, 8'h06, 8'h07, 2'b01, 25'h0, 1'b0, 1'b0));
		rows.push_back(cpu_step(OP_IOR, 18'h0DE00, 8'h00, 8'h00, 2'b01, 25'h0, 1'b0, 1'b0));
		// No cartridge so ROM reads float
		rows.push_back(set_id(`CRT_ID_NONE));
		rows.push_back(cpu_step(OP_RDL, 18'h00050, 8'h00, 8'h00, 2'b11, 25'h0100050, 1'b1, 1'b0));
	endtask

	// ******************************
	// Compare tasks
	// ******************************

	task automatic stop_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_lines(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: row %0d exrom/game %b, expected %b",
				$time, row_idx, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_addr(input crt_addr_t got, input crt_addr_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: row %0d addr_out %h, expected %h",
				$time, row_idx, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_float(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: row %0d data_floating %b, expected %b",
				$time, row_idx, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_wren(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: row %0d mem_write_out %b, expected %b",
				$time, row_idx, got, exp);
			stop_with_fail();
		end
	endtask

	// ******************************
	// Row execution
	// ******************************

	task automatic run_cpu_step(input row_t r);
		logic [7:0] rnd;
		rng_state = lcg_next(rng_state);
		rnd = rng_state[23:16];
		cart_loading = 1'b0;
		bus.addr = r.addr;
		bus.data = (rnd & ~r.mask) | (r.data & r.mask);   // Random filler in unused bits
		bus.mem_write = (r.op == OP_IOW) || (r.op == OP_WRL) || (r.op == OP_RAMW);
		bus.ioe = (r.op == OP_IOW) || (r.op == OP_IOR);
		bus.roml = (r.op == OP_RDL) || (r.op == OP_WRL);
		bus.romh = (r.op == OP_RDH);
		if (bus.ioe) begin
			repeat (2) @(negedge clk32);
			bus = '0;
			repeat (2) @(negedge clk32);
			check_lines({exrom, game}, r.lines);
		end else begin
			@(negedge clk32);
			check_lines({exrom, game}, r.lines);
			check_addr(addr_out, r.exp_addr);
			check_float(data_floating, r.flt);
			check_wren(mem_write_out, r.wren);
			bus = '0;
			@(negedge clk32);
		end
	endtask

	task automatic apply_row(input row_t r);
		int k;
		case (r.op)
			OP_ID: begin
				cart_id = r.arg;
				repeat (4) @(negedge clk32);   // Id change and then init
			end
			OP_LOAD: begin
				if (!cart_loading) begin
					cart_loading = 1'b1;          // Rising edge clears bank_cnt
					@(negedge clk32);
				end
				load.laddr = r.laddr;
				load.size = r.size;
				for (k = 0; k < int'(r.reps); k++) begin
					load.num = r.arg + 16'(k);
					load.raddr = r.raddr + (25'(k) << 13);
					load.wr = 1'b1;
					@(negedge clk32);
					load.wr = 1'b0;
					@(negedge clk32);
				end
			end
			default: run_cpu_step(r);
		endcase
	endtask

	// Limit scales with table length
	always @(posedge clk32) begin
		cycles <= cycles + 1;
		if (cycles > 4 * rows.size() * 8 + 100) begin
			$display("Timeout: stimulus table not finished after %0d cycles", cycles);
			stop_with_fail();
		end
	end

	initial begin
		clk32 = 1'b0;
		reset_n = 1'b1;
		cart_loading = 1'b0;
		cart_id = `CRT_ID_NONE;
		load = '0;
		bus = '0;
		cart_exrom0 = 1'b0;   // 16K generic image
		cart_game0 = 1'b0;
		fill_table();
		repeat (10) @(negedge clk32);
		reset_n = 1'b0;
		@(negedge clk32);
		for (row_idx = 0; row_idx < rows.size(); row_idx++)
			apply_row(rows[row_idx]);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* cartridge.sv */
// Cartridge mapper top with bank table, mapper controller and address translator
`timescale 1ns/1ps
`default_nettype none

module cartridge (
	input  logic               clk32,
	input  logic               reset_n,
	input  logic               cart_loading,
	input  crt_pkg::crt_id_t   cart_id,
	input  crt_pkg::crt_load_t load,
	input  crt_pkg::crt_bus_t  bus,
	input  logic               cart_exrom0,   // EXROM from CRT header
	input  logic               cart_game0,    // GAME from CRT header
	output logic               exrom,
	output logic               game,
	output crt_pkg::crt_addr_t addr_out,
	output logic               mem_write_out,
	output logic               data_floating
);
	import crt_pkg::*;

	logic [5:0] table_index;
	crt_bank_t  lo_entry;
	crt_bank_t  hi_entry;
	logic [7:0] bank_cnt;
	logic       big_bank_pulse;
	crt_cfg_t   cfg;

	crt_bank_table i_bank_table (
		.clk32          (clk32),
		.cart_loading   (cart_loading),
		.load           (load),
		.table_index    (table_index),
		.lo_entry       (lo_entry),
		.hi_entry       (hi_entry),
		.bank_cnt       (bank_cnt),
		.big_bank_pulse (big_bank_pulse)
	);

	crt_mapper_ctrl i_mapper_ctrl (
		.clk32          (clk32),
		.reset_n        (reset_n),
		.cart_id        (cart_id),
		.bus            (bus),
		.bank_cnt       (bank_cnt),
		.big_bank_pulse (big_bank_pulse),
		.lo_entry       (lo_entry),
		.hi_entry       (hi_entry),
		.cart_exrom0    (cart_exrom0),
		.cart_game0     (cart_game0),
		.table_index    (table_index),
		.cfg            (cfg)
	);

	crt_addr_xlate i_addr_xlate (
		.reset_n       (reset_n),
		.bus           (bus),
		.cfg           (cfg),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out),
		.data_floating (data_floating)
	);

	assign exrom = cfg.exrom;
	assign game  = cfg.game;

endmodule

`default_nettype wire

/* crt_addr_xlate.sv */
// CPU ROML/ROMH to external memory address translation and write blocking
`timescale 1ns/1ps
`default_nettype none

`include "crt_params.svh"

module crt_addr_xlate (
	input  logic               reset_n,
	input  crt_pkg::crt_bus_t  bus,
	input  crt_pkg::crt_cfg_t  cfg,
	output crt_pkg::crt_addr_t addr_out,
	output logic               mem_write_out,
	output logic               data_floating
);
	import crt_pkg::*;

	localparam crt_addr_t RAM_BASE = `CRT_RAM_BASE;
	localparam crt_addr_t ROM_BASE = `CRT_ROM_BASE;

	logic ultimax;

	assign ultimax = cfg.exrom && !cfg.game;

	// ******************************
	// Address mux
	// ******************************

	always_comb begin
		// Plain RAM access by default
		addr_out      = {RAM_BASE[24:18], bus.addr};
		data_floating = 1'b0;

		// No RAM behind ROML in ultimax mode
		mem_write_out = bus.mem_write && !(bus.roml && ultimax);

		if (!reset_n) begin
			if (bus.romh && !bus.mem_write) begin
				addr_out[24:13] = {ROM_BASE[24:20], cfg.bank_hi};
				data_floating   = ~cfg.hi_en;
			end

			// ROML wins when both are asserted
			if (bus.roml && !bus.mem_write) begin
				addr_out[24:13] = {ROM_BASE[24:20], cfg.bank_lo};
				data_floating   = ~cfg.lo_en;
			end
		end
	end

endmodule

`default_nettype wire

/* crt_mapper_ctrl.sv */
// Cartridge register state for generic, Ocean, Magic Desk and EasyFlash mappers
`timescale 1ns/1ps
`default_nettype none

`include "crt_params.svh"

module crt_mapper_ctrl (
	input  logic               clk32,
	input  logic               reset_n,
	input  crt_pkg::crt_id_t   cart_id,
	input  crt_pkg::crt_bus_t  bus,
	input  logic [7:0]         bank_cnt,
	input  logic               big_bank_pulse,
	input  crt_pkg::crt_bank_t lo_entry,
	input  crt_pkg::crt_bank_t hi_entry,
	input  logic               cart_exrom0,
	input  logic               cart_game0,
	output logic [5:0]         table_index,
	output crt_pkg::crt_cfg_t  cfg
);
	import crt_pkg::*;

	logic      ioe_q;
	logic      wr_stb;
	logic      init_n;     // Low during the init cycle
	crt_id_t   old_id;
	logic      id_change;
	crt_kind_e kind;

	// ******************************
	// IOE strobe
	// ******************************

	always_ff @(posedge clk32) begin
		if (reset_n)
			ioe_q <= 1'b0;
		else
			ioe_q <= bus.ioe;
	end

	assign wr_stb    = bus.ioe && !ioe_q && bus.mem_write;  // Reads are not decoded here
	assign id_change = old_id != cart_id;

	always_comb begin
		case (cart_id)
			`CRT_ID_GENERIC:   kind = CRT_GENERIC;
			`CRT_ID_OCEAN:     kind = CRT_OCEAN;
			`CRT_ID_MAGICDESK: kind = CRT_MAGICDESK;
			`CRT_ID_EASYFLASH: kind = CRT_EASYFLASH;
			`CRT_ID_NONE:      kind = CRT_NONE;
			default:           kind = CRT_OTHER;
		endcase
	end

	// EasyFlash bank select looks up the table, everything else wants entry 0
	assign table_index = (kind == CRT_EASYFLASH && wr_stb && !bus.addr[1]) ?
		bus.data[5:0] : 6'd0;

	// ******************************
	// Mapper registers
	// ******************************

	always_ff @(posedge clk32) begin
		old_id <= cart_id;
		init_n <= 1'b1;

		if (reset_n || id_change) begin
			cfg.exrom   <= 1'b1;
			cfg.game    <= 1'b1;
			cfg.bank_lo <= '0;
			cfg.bank_hi <= '0;
			cfg.lo_en   <= 1'b0;
			cfg.hi_en   <= 1'b0;
			init_n      <= 1'b0;
		end else if (kind == CRT_NONE) begin
			cfg.lo_en <= 1'b0;
			cfg.hi_en <= 1'b0;
		end else begin
			cfg.lo_en <= 1'b1;
			cfg.hi_en <= 1'b1;

			case (kind)
				CRT_GENERIC: begin
					// Lines straight from the CRT header
					cfg.exrom   <= cart_exrom0;
					cfg.game    <= cart_game0;
					cfg.bank_lo <= lo_entry;
					cfg.bank_hi <= hi_entry;
				end

				CRT_OCEAN: begin
					if (!init_n) begin
						cfg.exrom <= 1'b0;
						cfg.game  <= 1'b0;
					end
					if (wr_stb) begin
						cfg.bank_lo <= {1'b0, bus.data[5:0]};  // Same bank on both halves
						cfg.bank_hi <= {1'b0, bus.data[5:0]};
					end
					if (big_bank_pulse)
						cfg.game <= 1'b1;   // 512K image, ROMH back to RAM
				end

				CRT_MAGICDESK: begin
					if (!init_n) begin
						cfg.game    <= 1'b1;
						cfg.exrom   <= 1'b0;
						cfg.bank_lo <= '0;
					end
					if (wr_stb) begin
						if (bank_cnt <= 8'd16)
							cfg.bank_lo <= {3'd0, bus.data[3:0]};
						else if (bank_cnt <= 8'd32)
							cfg.bank_lo <= {2'd0, bus.data[4:0]};
						else if (bank_cnt <= 8'd64)
							cfg.bank_lo <= {1'b0, bus.data[5:0]};
						else
							cfg.bank_lo <= bus.data[6:0];
						cfg.exrom <= bus.data[7];   // Bit 7 hides the cartridge
					end
				end

				CRT_EASYFLASH: begin
					if (!init_n) begin
						cfg.exrom   <= 1'b1;      // Boots in ultimax
						cfg.game    <= 1'b0;
						cfg.bank_lo <= lo_entry;
						cfg.bank_hi <= hi_entry;
					end
					if (wr_stb) begin
						if (bus.addr[1]) begin
							// Control register, jumper assumed in boot position
							cfg.game  <= ~bus.data[0] & bus.data[2];
							cfg.exrom <= ~bus.data[1];
						end else begin
							cfg.bank_lo <= lo_entry;
							cfg.bank_hi <= hi_entry;
						end
					end
				end

				default: ;  // Unknown ids keep both banks enabled only
			endcase
		end
	end

	// EasyFlash banks must come from a valid table slot
	a_ef_bank_range: assert property (@(posedge clk32) disable iff (reset_n)
		(kind == CRT_EASYFLASH && init_n && !id_change) |->
		(cfg.bank_lo < 7'(`CRT_TABLE_DEPTH)))
		else $error("EasyFlash bank_lo out of table range");

endmodule

`default_nettype wire

/* crt_bank_table.sv */
// Bank location table with load counter and big bank detect
`timescale 1ns/1ps
`default_nettype none

`include "crt_params.svh"

module crt_bank_table (
	input  logic               clk32,
	input  logic               cart_loading,
	input  crt_pkg::crt_load_t load,
	input  logic [5:0]         table_index,
	output crt_pkg::crt_bank_t lo_entry,
	output crt_pkg::crt_bank_t hi_entry,
	output logic [7:0]         bank_cnt,
	output logic               big_bank_pulse
);
	import crt_pkg::*;

	crt_bank_t lo_banks [`CRT_TABLE_DEPTH];  // ROML side, $8000
	crt_bank_t hi_banks [`CRT_TABLE_DEPTH];  // ROMH side, $A000 or $E000

	logic      loading_q;
	crt_bank_t load_bank;
	logic      in_range;

	assign load_bank = load.raddr[19:13];                  // 8K slot within ROM window
	assign in_range  = load.num < 16'(`CRT_TABLE_DEPTH);

	// ******************************
	// Table writes
	// ******************************

	always_ff @(posedge clk32) begin
		if (load.wr && in_range) begin
			if (load.laddr <= 16'h8000) begin
				lo_banks[load.num[5:0]] <= load_bank;
				// 16K image spills into ROMH
				if (load.size > 16'h2000)
					hi_banks[load.num[5:0]] <= load_bank + 7'd1;
			end else begin
				hi_banks[load.num[5:0]] <= load_bank;
			end
		end
	end

	// Counter restarts with every new CRT file
	always_ff @(posedge clk32) begin
		loading_q <= cart_loading;
		if (cart_loading && !loading_q)
			bank_cnt <= 8'd0;
		if (load.wr)
			bank_cnt <= bank_cnt + 8'd1;
	end

	assign lo_entry       = lo_banks[table_index];
	assign hi_entry       = hi_banks[table_index];
	assign big_bank_pulse = load.wr && (load.num >= 16'd32);  // Ocean 512K layout

	// Loader only strobes inside a load window
	a_wr_in_loading: assert property (@(posedge clk32) load.wr |-> cart_loading)
		else $error("Bank write outside CRT loading");

endmodule

`default_nettype wire

/* crt_pkg.sv */
// Bank, address, id, cartridge kind and bus struct types for the cartridge mapper
`default_nettype none

package crt_pkg;

	// ******************************
	// Scalar types
	// ******************************

	typedef logic [6:0]  crt_bank_t; // Bank number in 8K units
	typedef logic [24:0] crt_addr_t; // External memory address
	typedef logic [15:0] crt_id_t;   // CRT hardware type

	// Decoded cartridge kind
	typedef enum logic [2:0] {
		CRT_GENERIC,
		CRT_OCEAN,
		CRT_MAGICDESK,
		CRT_EASYFLASH,
		CRT_NONE,
		CRT_OTHER
	} crt_kind_e;

	// ******************************
	// Structs
	// ******************************

	// One CHIP packet from the CRT loader
	typedef struct packed {
		logic [15:0] laddr;  // Load address in C64 space
		logic [15:0] size;   // Image size in bytes
		logic [15:0] num;    // Bank number
		crt_addr_t   raddr;  // Where the packet landed
		logic        wr;     // One pulse per bank
	} crt_load_t;

	// CPU side of the expansion port
	typedef struct packed {
		logic        roml;
		logic        romh;
		logic        ioe;
		logic        mem_write;
		logic [17:0] addr;
		logic [7:0]  data;
	} crt_bus_t;

	// Mapping state seen by the translator
	typedef struct packed {
		logic      exrom;
		logic      game;
		crt_bank_t bank_lo;
		crt_bank_t bank_hi;
		logic      lo_en;
		logic      hi_en;
	} crt_cfg_t;

endpackage

`default_nettype wire

/* crt_params.svh */
// Memory base addresses, bank table depth and cartridge id macros
`ifndef CRT_PARAMS_SVH
`define CRT_PARAMS_SVH

// ******************************
// Memory map
// ******************************

// C64 RAM sits at the bottom of external memory
`define CRT_RAM_BASE 25'h0000000

// Cartridge ROM banks, 1MB window
`define CRT_ROM_BASE 25'h0100000

// ******************************
// Bank table
// ******************************

`define CRT_TABLE_DEPTH 64       // Entries of 8K each

// ******************************
// Cartridge ids from CRT header
// ******************************

`define CRT_ID_GENERIC   16'd0
`define CRT_ID_OCEAN     16'd5   // Ocean type 1
`define CRT_ID_MAGICDESK 16'd19
`define CRT_ID_EASYFLASH 16'd32
`define CRT_ID_NONE      16'd255 // No cartridge inserted

`endif
